// ==== project.f ====
+incdir+hw
hw/rv_ops_pkg.sv
hw/dmem_bus_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/axil_mem_port.sv
hw/dmem_arbiter.sv
hw/data_ram.sv
hw/exec_backend_top.sv
bench/exec_backend_tb.sv

// ==== bench/exec_backend_tests.txt ====
# Fields in hex: M/C addr data, E rd data, B target, S, or I pc imm rs1 rs2 rd alu sel br ld st wr
# E and B give the result of the next I; S waits until all traffic and results are done
M 00000040 cafef00d
S
E 01 80000000
I 00000000 80000000 00 00 01 0 2 0 0 0 1
E 02 ffffffff
I 00000004 ffffffff 00 00 02 0 1 0 0 0 1
E 03 7fffffff
I 00000008 00000000 01 02 03 0 0 0 0 0 1
E 04 80000001
I 0000000c 00000000 01 02 04 1 0 0 0 0 1
E 05 00000001
I 00000010 00000000 01 02 05 8 0 0 0 0 1
E 06 00000000
I 00000014 00000000 02 01 06 9 0 0 0 0 1
E 07 c0000000
I 00000018 00000001 01 00 07 7 1 0 0 0 1
E 08 40000000
I 0000001c 00000001 01 00 08 6 1 0 0 0 1
E 09 fffffff0
I 00000020 00000004 02 00 09 5 1 0 0 0 1
E 0a fffff0ff
I 00000024 00000f0f 09 00 0a 4 1 0 0 0 1
E 0b 00ff00f0
I 00000028 00ff0ff0 0a 00 0b 2 1 0 0 0 1
E 0c 40ff00f0
I 0000002c 00000000 0b 08 0c 3 0 0 0 0 1
E 0d 12345100
I 00000100 12345000 00 00 0d 0 3 0 0 0 1
I 00000104 00000005 02 00 00 0 1 0 0 0 1
E 0e 40ff00f0
I 00000108 00000000 00 0c 0e 0 0 0 0 0 1
B 00000210
I 00000200 00000010 01 01 00 0 0 1 0 0 0
I 00000204 00000010 01 01 00 0 0 2 0 0 0
B 000001f8
I 00000208 fffffff0 01 02 00 0 0 3 0 0 0
B 0000021c
I 0000020c 00000010 02 01 00 0 0 4 0 0 0
I 00000210 00000010 02 01 00 0 0 3 0 0 0
B 00000224
I 00000214 00000010 01 02 00 0 0 5 0 0 0
I 00000218 00000010 01 02 00 0 0 6 0 0 0
B 00000230
I 00000220 00000010 05 05 00 0 0 6 0 0 0
M 000000c0 a5a5a5a5
C 00000040 cafef00d
E 0f cafef00d
I 00000300 00000040 00 00 0f 0 1 0 1 0 1
I 00000304 00000080 00 0c 00 0 1 0 0 1 0
E 10 cafef00e
I 00000308 00000001 0f 00 10 0 1 0 0 0 1
M 000000c4 5a5a5a5a
E 11 40ff00f0
I 0000030c 00000080 00 00 11 0 1 0 1 0 1
E 12 95fde01c
I 00000310 00000000 10 10 12 0 0 0 0 0 1
E 13 81fe01e0
I 00000314 00000000 11 0e 13 0 0 0 0 0 1
I 00000318 00000084 00 13 00 0 1 0 0 1 0
S
C 00000080 40ff00f0
C 00000084 81fe01e0
C 000000c0 a5a5a5a5
C 000000c4 5a5a5a5a

// ==== bench/exec_backend_tb.sv ====
// Testbench for the execute/memory back end, driven by the command file in bench
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module exec_backend_tb
    import rv_ops_pkg::*;
    import dmem_bus_pkg::*;
();

    logic             clk, rst;
    issue_op_t        issue_op;
    logic             issue_valid, issue_ready;
    logic             redirect_valid;
    logic [`XLEN-1:0] redirect_target;
    wb_t              wb;
    axil_aw_t         aw;
    axil_w_t          w;
    axil_b_t          b;
    axil_ar_t         ar;
    axil_r_t          r;
    logic             awready, wready, bready, arready, rready;

    integer           seed;
    logic             loaded;
    logic [7:0]       kind_q[$];     // One letter per command
    logic [31:0]      arg_q[$];      // Eleven fields per command
    wb_t              exp_wb_q[$];   // Writebacks in issue order
    logic [`XLEN-1:0] exp_redir_q[$];
    logic             axi_wr_q[$];   // Pending debug accesses
    logic [31:0]      axi_addr_q[$];
    logic [31:0]      axi_data_q[$];

    exec_backend_top exec_backend_top_i (
        .clk(clk), .rst(rst), .issue_op(issue_op), .issue_valid(issue_valid),
        .issue_ready(issue_ready), .redirect_valid(redirect_valid),
        .redirect_target(redirect_target), .wb(wb),
        .aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
        .ar(ar), .arready(arready), .r(r), .rready(rready));

    always #10 clk = ~clk; // 20 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got.rd !== exp.rd || got.data !== exp.data)
            abort_run($sformatf("CHECK FAILED wb: got rd=%h data=%h, expected rd=%h data=%h",
                                got.rd, got.data, exp.rd, exp.data));
    endtask

    task automatic check_redirect(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED redirect_target: got %h, expected %h", got, exp));
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // Debug port must always answer OKAY
    task automatic check_resp(input string name, input logic [1:0] got);
        if (got !== 2'b00)
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, 2'b00));
    endtask

    task automatic load_tests();
        integer      fd, code, i, nargs;
        logic [63:0] tok;
        logic [1023:0] line;
        logic [31:0] v;
        fd = $fopen("bench/exec_backend_tests.txt", "r");
        if (fd == 0)
            abort_run("Cannot open bench/exec_backend_tests.txt");
        code = $fscanf(fd, " %s", tok);
        while (code == 1)
        begin
            if (tok == "#")
                code = $fgets(line, fd); // Rest of a comment line
            else
            begin
                case (tok[7:0])
                    "I":     nargs = 11;
                    "S":     nargs = 0;
                    "B":     nargs = 1;
                    default: nargs = 2;
                endcase
                kind_q.push_back(tok[7:0]);
                for (i = 0; i < 11; i++)
                begin
                    v = '0;
                    if (i < nargs && $fscanf(fd, " %h", v) != 1)
                        abort_run($sformatf("Command %0d in the test file is incomplete",
                                            kind_q.size()));
                    arg_q.push_back(v);
                end
            end
            code = $fscanf(fd, " %s", tok);
        end
        $fclose(fd);
    endtask

    // Called on a falling edge; returns on the falling edge after acceptance
    task automatic issue(input issue_op_t op);
        issue_op    = op;
        issue_valid = 1'b1;
        while (!issue_ready) // Memory stage holding the pipeline
            @(negedge clk);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        aw.addr  = addr;
        aw.valid = 1'b1;
        w.data   = data;
        w.valid  = 1'b1;
        #1; // awready follows valid combinationally
        while (!awready)
        begin
            @(negedge clk);
            #1;
        end
        if (!wready)
            abort_run("The write data was not accepted together with the write address");
        @(negedge clk);
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        while (!b.valid)
            @(negedge clk);
        repeat ($unsigned($random(seed)) % 3) @(negedge clk); // B back-pressure
        check_resp("bresp", b.resp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data);
        ar.addr  = addr;
        ar.valid = 1'b1;
        #1;
        while (!arready)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ar.valid = 1'b0;
        while (!r.valid)
            @(negedge clk);
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        check_word("rdata", r.data, exp_data);
        check_resp("rresp", r.resp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Let debug traffic and the pipeline empty, then let stores land
    task automatic drain();
        int cycles;
        cycles = 0;
        while (axi_addr_q.size() != 0 || !issue_ready)
            @(negedge clk);
        while ((exp_wb_q.size() != 0 || exp_redir_q.size() != 0) && cycles < 16)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_wb_q.size() != 0 || exp_redir_q.size() != 0)
            abort_run("Expected writebacks or redirects never arrived");
        repeat (4) @(negedge clk);
    endtask

    task automatic run_command(input logic [7:0] kind, input int base);
        issue_op_t   op;
        wb_t         exp;
        logic [31:0] a [0:10];
        int          k;
        for (k = 0; k < 11; k++)
            a[k] = arg_q[base + k];
        case (kind)
            "M", "C":
            begin
                axi_wr_q.push_back(kind == "M");
                axi_addr_q.push_back(a[0]);
                axi_data_q.push_back(a[1]);
            end
            "I":
            begin
                op.pc        = a[0];
                op.imm       = a[1];
                op.rs1       = a[2][4:0];
                op.rs2       = a[3][4:0];
                op.rd        = a[4][4:0];
                op.alu_op    = alu_op_t'(a[5][3:0]);
                op.opnd_sel  = opnd_sel_t'(a[6][1:0]);
                op.branch    = branch_t'(a[7][2:0]);
                op.mem_read  = a[8][0];
                op.mem_write = a[9][0];
                op.reg_write = a[10][0];
                issue(op);
            end
            "E":
            begin
                exp.rd    = a[0][4:0];
                exp.data  = a[1];
                exp.valid = 1'b1;
                exp_wb_q.push_back(exp);
            end
            "B": exp_redir_q.push_back(a[0]);
            "S": drain();
            default: abort_run($sformatf("Unknown command %s in the test file", kind));
        endcase
    endtask

    // Debug port worker waits a random idle gap before each access
    always @(negedge clk)
    begin
        if (!rst && axi_addr_q.size() != 0)
        begin
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
            if (axi_wr_q[0])
                axi_write(axi_addr_q[0], axi_data_q[0]);
            else
                axi_read(axi_addr_q[0], axi_data_q[0]);
            void'(axi_wr_q.pop_front()); // Popped last so drain sees it busy
            void'(axi_addr_q.pop_front());
            void'(axi_data_q.pop_front());
        end
    end

    always @(negedge clk)
    begin
        if (!rst && wb.valid)
        begin
            if (exp_wb_q.size() == 0)
                abort_run($sformatf("Writeback to register %0d was not expected", wb.rd));
            else
                check_wb(wb, exp_wb_q.pop_front());
        end
    end

    always @(negedge clk)
    begin
        if (!rst && redirect_valid)
        begin
            if (exp_redir_q.size() == 0)
                abort_run($sformatf("Redirect to %h was not expected", redirect_target));
            else
                check_redirect(redirect_target, exp_redir_q.pop_front());
        end
    end

    // Watchdog allows 40 cycles per command
    initial
    begin
        wait (loaded);
        repeat (kind_q.size() * 40) @(posedge clk);
        abort_run($sformatf("The run timed out after %0d cycles", kind_q.size() * 40));
    end

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        seed        = 32'hc3ed_247e;
        loaded      = 1'b0;
        issue_op    = '0;
        issue_valid = 1'b0;
        aw          = '0;
        w           = '0;
        ar          = '0;
        bready      = 1'b0;
        rready      = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < kind_q.size(); i++)
            run_command(kind_q[i], i * 11);
        drain();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/exec_backend_top.sv ====
// Execute/memory back end: register file, pipeline, shared RAM and debug port
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module exec_backend_top
    import rv_ops_pkg::*;
    import dmem_bus_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  issue_op_t        issue_op,
    input  wire              issue_valid,
    output logic             issue_ready,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_target,
    output wb_t              wb,
    input  axil_aw_t         aw,
    output logic             awready,
    input  axil_w_t          w,
    output logic             wready,
    output axil_b_t          b,
    input  wire              bready,
    input  axil_ar_t         ar,
    output logic             arready,
    output axil_r_t          r,
    input  wire              rready
);

    logic [`XLEN-1:0] rs1_value, rs2_value, exmem_data;
    logic [4:0]       exmem_rd;
    logic             exmem_ok, stall, core_gnt, dbg_gnt;
    ex_mem_t          ex_mem;
    mem_req_t         core_req, dbg_req, ram_req;
    mem_rsp_t         core_rsp, dbg_rsp, ram_rsp;

    assign issue_ready = !stall;

    reg_file reg_file_i (.clk(clk), .rst(rst), .raddr1(issue_op.rs1), .raddr2(issue_op.rs2),
                         .rdata1(rs1_value), .rdata2(rs2_value), .wr(wb));

    execute_stage execute_stage_i (
        .clk(clk), .rst(rst), .op(issue_op), .op_valid(issue_valid),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .stall(stall),
        .fwd_exmem_rd(exmem_rd), .fwd_exmem_data(exmem_data), .fwd_exmem_ok(exmem_ok),
        .fwd_wb(wb), .ex_out(ex_mem),
        .redirect_valid(redirect_valid), .redirect_target(redirect_target));

    mem_stage mem_stage_i (
        .clk(clk), .rst(rst), .ex_in(ex_mem), .req(core_req), .gnt(core_gnt), .rsp(core_rsp),
        .stall(stall), .exmem_rd(exmem_rd), .exmem_data(exmem_data), .exmem_ok(exmem_ok),
        .wb(wb));

    axil_mem_port axil_mem_port_i (
        .clk(clk), .rst(rst), .aw(aw), .w(w), .awready(awready), .wready(wready),
        .b(b), .bready(bready), .ar(ar), .arready(arready), .r(r), .rready(rready),
        .req(dbg_req), .gnt(dbg_gnt), .rsp(dbg_rsp));

    dmem_arbiter dmem_arbiter_i (
        .clk(clk), .rst(rst),
        .core_req(core_req), .core_gnt(core_gnt), .core_rsp(core_rsp),
        .dbg_req(dbg_req), .dbg_gnt(dbg_gnt), .dbg_rsp(dbg_rsp),
        .ram_req(ram_req), .ram_rsp(ram_rsp));

    data_ram data_ram_i (.clk(clk), .req(ram_req), .rsp(ram_rsp));

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
// Single-port word RAM, write on the edge and registered read
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module data_ram
    import dmem_bus_pkg::*;
(
    input  wire      clk,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (req.valid && req.write)
            mem[req.addr] <= req.wdata;
        rsp.rdata <= mem[req.addr]; // Old data on a write
        rsp.valid <= req.valid;     // Writes get an answer too
    end

endmodule

`default_nettype wire

// ==== hw/dmem_arbiter.sv ====
// Round-robin arbiter sharing the data RAM between core and debug port
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter
    import dmem_bus_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  mem_req_t core_req,
    output logic     core_gnt,
    output mem_rsp_t core_rsp,
    input  mem_req_t dbg_req,
    output logic     dbg_gnt,
    output mem_rsp_t dbg_rsp,
    output mem_req_t ram_req,
    input  mem_rsp_t ram_rsp
);

    logic last_dbg;  // Last grant went to debug; reset favours core
    logic rsp_pend;  // RAM answers this cycle
    logic owner_dbg; // Whose request that answer belongs to

    assign core_gnt = core_req.valid && (!dbg_req.valid || last_dbg);
    assign dbg_gnt  = dbg_req.valid && (!core_req.valid || !last_dbg);

    always_comb
    begin
        ram_req = '0;
        if (core_gnt)
            ram_req = core_req;
        else if (dbg_gnt)
            ram_req = dbg_req;
    end

    assign core_rsp = '{valid: rsp_pend && ram_rsp.valid && !owner_dbg, rdata: ram_rsp.rdata};
    assign dbg_rsp  = '{valid: rsp_pend && ram_rsp.valid && owner_dbg, rdata: ram_rsp.rdata};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_dbg  <= 1'b1;
            rsp_pend  <= 1'b0;
            owner_dbg <= 1'b0;
        end
        else
        begin
            rsp_pend  <= core_gnt || dbg_gnt;
            owner_dbg <= dbg_gnt;
            if (core_gnt || dbg_gnt)
                last_dbg <= dbg_gnt;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst) !(core_gnt && dbg_gnt));

endmodule

`default_nettype wire

// ==== hw/axil_mem_port.sv ====
// AXI4-Lite debug slave that turns each access into one RAM request
`timescale 1ns/1ps
`default_nettype none

module axil_mem_port
    import dmem_bus_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  axil_aw_t aw,
    input  axil_w_t  w,
    output logic     awready,
    output logic     wready,
    output axil_b_t  b,
    input  wire      bready,
    input  axil_ar_t ar,
    output logic     arready,
    output axil_r_t  r,
    input  wire      rready,
    output mem_req_t req,
    input  wire      gnt,
    input  mem_rsp_t rsp
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT, RESP} state_t;

    state_t                  state;
    logic                    is_wr;
    logic [DMEM_AW-1:0]      addr_q;
    logic [$bits(w.data)-1:0] wdata_q, rdata_q;
    logic                    wr_go, rd_go;

    assign wr_go   = state == IDLE && aw.valid && w.valid; // AW and W taken together
    assign rd_go   = state == IDLE && ar.valid && !wr_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign req = '{valid: state == REQ, write: is_wr, addr: addr_q, wdata: wdata_q};
    assign b   = '{valid: state == RESP && is_wr, resp: 2'b00};
    assign r   = '{valid: state == RESP && !is_wr, data: rdata_q, resp: 2'b00};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            is_wr <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE: if (wr_go || rd_go)
                begin
                    state <= REQ;
                    is_wr <= wr_go;
                end
                REQ:  if (gnt) state <= WAIT;
                WAIT: if (rsp.valid) state <= RESP;
                default: if ((is_wr && bready) || (!is_wr && rready)) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_go)
        begin
            addr_q  <= aw.addr[DMEM_AW+1:2];
            wdata_q <= w.data;
        end
        else if (rd_go)
            addr_q <= ar.addr[DMEM_AW+1:2];
        if (state == WAIT && rsp.valid)
            rdata_q <= rsp.rdata;
    end

    a_b_held: assert property (@(posedge clk) disable iff (rst)
        b.valid && !bready |=> b.valid);

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
// Memory stage: EX/MEM and MEM/WB registers, RAM access and pipeline hold
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module mem_stage
    import rv_ops_pkg::*;
    import dmem_bus_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  ex_mem_t          ex_in,
    output mem_req_t         req,
    input  wire              gnt,
    input  mem_rsp_t         rsp,
    output logic             stall,
    output logic [4:0]       exmem_rd,
    output logic [`XLEN-1:0] exmem_data,
    output logic             exmem_ok,
    output wb_t              wb
);

    ex_mem_t exmem;
    logic    req_pend;  // Request waiting for grant
    logic    wait_rsp;  // Granted, RAM answers next cycle
    logic    is_mem;

    assign is_mem = exmem.valid && (exmem.mem_read || exmem.mem_write);
    assign stall  = is_mem && !(wait_rsp && rsp.valid);

    assign req = '{valid: req_pend, write: exmem.mem_write,
                   addr: exmem.result[DMEM_AW+1:2], wdata: exmem.store_data};

    // Loads have no data yet in EX/MEM
    assign exmem_rd   = exmem.rd;
    assign exmem_data = exmem.result;
    assign exmem_ok   = exmem.valid && exmem.reg_write && !exmem.mem_read && exmem.rd != 5'd0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exmem.valid <= 1'b0;
            req_pend    <= 1'b0;
            wait_rsp    <= 1'b0;
            wb.valid    <= 1'b0;
        end
        else if (!stall)
        begin
            exmem    <= ex_in;
            req_pend <= ex_in.valid && (ex_in.mem_read || ex_in.mem_write);
            wait_rsp <= 1'b0;
            wb.valid <= exmem.valid && exmem.reg_write && exmem.rd != 5'd0;
            wb.rd    <= exmem.rd;
            wb.data  <= exmem.mem_read ? rsp.rdata : exmem.result;
        end
        else
        begin
            wb.valid <= 1'b0; // One pulse per retired op
            if (req_pend && gnt)
            begin
                req_pend <= 1'b0;
                wait_rsp <= 1'b1;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req.valid && !gnt |=> req.valid && $stable(req));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
// Execute stage: ID/EX register, forwarding, ALU and branch resolution
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execute_stage
    import rv_ops_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  issue_op_t        op,
    input  wire              op_valid,
    input  wire [`XLEN-1:0]  rs1_value,
    input  wire [`XLEN-1:0]  rs2_value,
    input  wire              stall,
    input  wire [4:0]        fwd_exmem_rd,
    input  wire [`XLEN-1:0]  fwd_exmem_data,
    input  wire              fwd_exmem_ok,
    input  wb_t              fwd_wb,
    output ex_mem_t          ex_out,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_target
);

    issue_op_t        idex_op;
    logic             idex_valid;
    logic             redirect_done; // Redirect already shown during a stall
    logic [`XLEN-1:0] rs1_q, rs2_q;
    logic [`XLEN-1:0] rs1_f, rs2_f;
    logic [`XLEN-1:0] alu_a, alu_b, alu_y;
    logic             taken;

    // EX/MEM first, then MEM/WB; x0 never forwarded
    function automatic logic [`XLEN-1:0] fwd(input logic [4:0] rs, input logic [`XLEN-1:0] q,
                                             input logic [4:0] ex_rd,
                                             input logic [`XLEN-1:0] ex_data,
                                             input logic ex_ok, input wb_t wb_in);
        if (rs != 5'd0 && ex_ok && ex_rd == rs)
            return ex_data;
        else if (rs != 5'd0 && wb_in.valid && wb_in.rd == rs)
            return wb_in.data;
        return q;
    endfunction

    assign rs1_f = fwd(idex_op.rs1, rs1_q, fwd_exmem_rd, fwd_exmem_data, fwd_exmem_ok, fwd_wb);
    assign rs2_f = fwd(idex_op.rs2, rs2_q, fwd_exmem_rd, fwd_exmem_data, fwd_exmem_ok, fwd_wb);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idex_valid    <= 1'b0;
            redirect_done <= 1'b0;
        end
        else if (!stall)
        begin
            idex_valid    <= op_valid;
            redirect_done <= 1'b0;
        end
        else if (redirect_valid)
            redirect_done <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            idex_op <= op;
            rs1_q   <= rs1_value; // Register file writes through
            rs2_q   <= rs2_value;
        end
        else
        begin
            // Producers retire while frozen, so keep the forwarded copy
            rs1_q <= rs1_f;
            rs2_q <= rs2_f;
        end
    end

    always_comb
    begin
        case (idex_op.opnd_sel)
            RS1_RS2:  begin alu_a = rs1_f;      alu_b = rs2_f;       end
            RS1_IMM:  begin alu_a = rs1_f;      alu_b = idex_op.imm; end
            IMM_ZERO: begin alu_a = idex_op.imm; alu_b = '0;         end
            default:  begin alu_a = idex_op.pc;  alu_b = idex_op.imm; end
        endcase
    end

    alu alu_i (.op(idex_op.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    always_comb
    begin
        case (idex_op.branch)
            BR_BEQ:  taken = rs1_f == rs2_f;
            BR_BNE:  taken = rs1_f != rs2_f;
            BR_BLT:  taken = $signed(rs1_f) < $signed(rs2_f);
            BR_BGE:  taken = $signed(rs1_f) >= $signed(rs2_f);
            BR_BLTU: taken = rs1_f < rs2_f;
            BR_BGEU: taken = rs1_f >= rs2_f;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid  = idex_valid && taken && !redirect_done;
    assign redirect_target = idex_op.pc + idex_op.imm;

    assign ex_out = '{valid: idex_valid, rd: idex_op.rd, reg_write: idex_op.reg_write,
                      mem_read: idex_op.mem_read, mem_write: idex_op.mem_write,
                      result: alu_y, store_data: rs2_f};

    // Frozen op and its forwarded operands must not change until memory stage releases it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(idex_op) && $stable(idex_valid) && $stable(rs1_f) && $stable(rs2_f));

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
// Register file, two async reads and one write, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reg_file
    import rv_ops_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire [4:0]        raddr1,
    input  wire [4:0]        raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  wb_t              wr
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (wr.valid && wr.rd != 5'd0)
            regs[wr.rd] <= wr.data;
    end

    // Same-cycle write is visible to the reader
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (wr.valid && wr.rd == raddr1) ? wr.data : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (wr.valid && wr.rd == raddr2) ? wr.data : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// Integer ALU for the RV32I register and immediate operations
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module alu
    import rv_ops_pkg::*;
(
    input  alu_op_t          op,
    input  wire [`XLEN-1:0]  a,
    input  wire [`XLEN-1:0]  b,
    output logic [`XLEN-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only low five bits count for shifts

    always_comb
    begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
            ALU_SLT:  y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`XLEN-1){1'b0}}, a < b};
            default:  y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/dmem_bus_pkg.sv ====
// Memory traffic types: RAM request/response and AXI4-Lite channel payloads
`default_nettype none

`include "core_settings.svh"

package dmem_bus_pkg;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS); // Word address width

    typedef struct packed {
        logic               valid;
        logic               write;
        logic [DMEM_AW-1:0] addr;
        logic [`XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] data;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] data;
        logic [1:0]       resp;
    } axil_r_t;

endpackage

`default_nettype wire

// ==== hw/rv_ops_pkg.sv ====
// Operation types: ALU codes, operand forms, branch kinds and pipeline bundles
`default_nettype none

`include "core_settings.svh"

package rv_ops_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    // Which pair feeds the ALU
    typedef enum logic [1:0] {
        RS1_RS2,  // R-type
        RS1_IMM,  // I-type, loads, stores
        IMM_ZERO, // LUI
        PC_IMM    // AUIPC
    } opnd_sel_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_t;

    // Decoded operation as sent by the issuer
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        alu_op_t          alu_op;
        opnd_sel_t        opnd_sel;
        branch_t          branch;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
    } issue_op_t;

    typedef struct packed {
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic             valid;
    } wb_t;

    // Execute to memory stage
    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        logic [`XLEN-1:0] result;     // ALU result, also the byte address
        logic [`XLEN-1:0] store_data; // Forwarded rs2
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== hw/core_settings.svh ====
// Core build constants shared by packages and modules
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Data RAM depth in 32-bit words
`define DMEM_WORDS 256

`endif
